// ==== source/uart_config.svh ====
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

////////////////////////////////////////////////////////////
// serial timing
////////////////////////////////////////////////////////////
`define UART_CLOCKS_PER_BIT 8

////////////////////////////////////////////////////////////
// register map
////////////////////////////////////////////////////////////
`define UART_RX_OFFSET 32'h0000_0000
`define UART_TX_OFFSET 32'h0000_0004

`endif

// ==== source/bus_pkg.sv ====
package bus_pkg;

  ////////////////////////////////////////////////////////////
  // valid/ready memory bus
  ////////////////////////////////////////////////////////////

  // request, held steady by the master until mem_ready.
  typedef struct packed {
    logic        mem_valid;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;  // all zero for a read.
  } mem_in_type;

  // response, valid only while mem_ready is high.
  typedef struct packed {
    logic        mem_ready;  // one-cycle pulse.
    logic        mem_error;
    logic [31:0] mem_rdata;
  } mem_out_type;

  localparam mem_out_type mem_out_idle = '{
    mem_ready : 1'b0,
    mem_error : 1'b0,
    mem_rdata : 32'h0
  };

endpackage

// ==== source/uart_pkg.sv ====
package uart_pkg;

  ////////////////////////////////////////////////////////////
  // state machines
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_type;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_type;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    target_none,
    target_rx,
    target_tx
  } target_type;

endpackage

// ==== source/uart_rx.sv ====
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_rx #(
  parameter int clocks_per_bit = `UART_CLOCKS_PER_BIT
) (
  input  logic                clock,
  input  logic                reset,
  input  bus_pkg::mem_in_type  bus_in,
  output bus_pkg::mem_out_type bus_out,
  output logic                irpt,
  input  logic                rx
);

  localparam int count_width = (clocks_per_bit > 2) ? $clog2(clocks_per_bit) : 1;
  localparam logic [count_width-1:0] full = count_width'(clocks_per_bit - 1);
  localparam logic [count_width-1:0] half = count_width'(clocks_per_bit / 2 - 1);

  typedef struct packed {
    uart_pkg::rx_state_type   state;
    logic [2:0]               bit_count;
    logic [count_width-1:0]   cycle_count;
    logic [7:0]               data;
    logic [7:0]               data_re;
    logic                     state_re;  // read waiting for the next frame.
    logic                     irpt_re;   // read of a pending byte.
    logic                     done;
    logic                     ready_re;
    logic                     irpt;
    logic                     rx_meta;
    logic                     rx_sync;
    logic                     rx_prev;
  } register_type;

  localparam register_type init_register = '{
    state       : uart_pkg::rx_idle,
    bit_count   : '0,
    cycle_count : '0,
    data        : '0,
    data_re     : '0,
    state_re    : 1'b0,
    irpt_re     : 1'b0,
    done        : 1'b0,
    ready_re    : 1'b0,
    irpt        : 1'b0,
    rx_meta     : 1'b1,  // idle line level.
    rx_sync     : 1'b1,
    rx_prev     : 1'b1
  };

  register_type r, v;

  logic read_req;
  logic busy;

  assign read_req = bus_in.mem_valid && (bus_in.mem_wstrb == 4'b0000);
  assign busy     = r.state_re || r.irpt_re || r.ready_re;  // one pending read at a time.

  always_comb begin
    v = r;

    v.rx_meta     = rx;
    v.rx_sync     = r.rx_meta;
    v.rx_prev     = r.rx_sync;
    v.cycle_count = r.cycle_count + 1'b1;
    v.done        = 1'b0;
    v.ready_re    = 1'b0;
    v.data_re     = '0;

    if (read_req && !busy) begin
      if (r.irpt) begin
        v.irpt_re = 1'b1;
      end else begin
        v.state_re = 1'b1;
      end
    end

    ////////////////////////////////////////////////////////////
    // answer a pending read
    ////////////////////////////////////////////////////////////
    if (r.state_re && r.done) begin
      v.ready_re = 1'b1;
      v.state_re = 1'b0;
      v.irpt     = 1'b0;
      v.data_re  = r.data;
    end

    if (r.irpt_re && r.irpt) begin
      v.ready_re = 1'b1;
      v.irpt_re  = 1'b0;
      v.irpt     = 1'b0;
      v.data_re  = r.data;
    end

    ////////////////////////////////////////////////////////////
    // frame reception
    ////////////////////////////////////////////////////////////
    case (r.state)
      uart_pkg::rx_idle: begin
        v.cycle_count = '0;
        v.bit_count   = '0;
        if (r.rx_prev && !r.rx_sync) begin
          v.state = uart_pkg::rx_start;  // falling edge of start bit.
        end
      end
      uart_pkg::rx_start: begin
        if (r.cycle_count == half) begin
          v.cycle_count = '0;
          // glitch if the line is already back high.
          v.state = r.rx_sync ? uart_pkg::rx_idle : uart_pkg::rx_data;
        end
      end
      uart_pkg::rx_data: begin
        if (r.cycle_count == full) begin
          v.cycle_count = '0;
          v.data        = {r.rx_sync, r.data[7:1]};  // lsb first.
          v.bit_count   = r.bit_count + 3'd1;
          if (r.bit_count == 3'd7) begin
            v.state = uart_pkg::rx_stop;
          end
        end
      end
      uart_pkg::rx_stop: begin
        if (r.cycle_count == full) begin
          v.state = uart_pkg::rx_idle;
          v.done  = 1'b1;
          v.irpt  = !v.state_re;  // no interrupt when a read takes the byte.
        end
      end
      default: v.state = uart_pkg::rx_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      r <= init_register;
    end else begin
      r <= v;
    end
  end

  assign bus_out.mem_ready = r.ready_re;
  assign bus_out.mem_error = 1'b0;
  assign bus_out.mem_rdata = {24'h0, r.data_re};
  assign irpt              = r.irpt;

  // the bus expects a single-cycle acknowledge.
  ready_pulse : assert property (
    @(posedge clock) disable iff (reset == 1'b0)
    bus_out.mem_ready |=> !bus_out.mem_ready
  );

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_tx #(
  parameter int clocks_per_bit = `UART_CLOCKS_PER_BIT
) (
  input  logic                clock,
  input  logic                reset,
  input  bus_pkg::mem_in_type  bus_in,
  output bus_pkg::mem_out_type bus_out,
  output logic                tx
);

  localparam int count_width = (clocks_per_bit > 2) ? $clog2(clocks_per_bit) : 1;
  localparam logic [count_width-1:0] full = count_width'(clocks_per_bit - 1);

  typedef struct packed {
    uart_pkg::tx_state_type state;
    logic [2:0]             bit_count;
    logic [count_width-1:0] cycle_count;
    logic [7:0]             shift;
    logic                   tx;
    logic                   ready;
  } register_type;

  localparam register_type init_register = '{
    state       : uart_pkg::tx_idle,
    bit_count   : '0,
    cycle_count : '0,
    shift       : '0,
    tx          : 1'b1,
    ready       : 1'b0
  };

  register_type r, v;

  logic write_req;

  // a request still held during the acknowledge is the same write.
  assign write_req = bus_in.mem_valid && (bus_in.mem_wstrb != 4'b0000) && !r.ready;

  always_comb begin
    v = r;

    v.cycle_count = r.cycle_count + 1'b1;
    v.ready       = 1'b0;

    case (r.state)
      uart_pkg::tx_idle: begin
        v.cycle_count = '0;
        v.bit_count   = '0;
        v.tx          = 1'b1;
        if (write_req) begin
          v.state = uart_pkg::tx_start;
          v.shift = bus_in.mem_wdata[7:0];
          v.tx    = 1'b0;  // start bit.
        end
      end
      uart_pkg::tx_start: begin
        if (r.cycle_count == full) begin
          v.cycle_count = '0;
          v.state       = uart_pkg::tx_data;
          v.tx          = r.shift[0];
        end
      end
      uart_pkg::tx_data: begin
        if (r.cycle_count == full) begin
          v.cycle_count = '0;
          v.bit_count   = r.bit_count + 3'd1;
          v.shift       = {1'b0, r.shift[7:1]};
          if (r.bit_count == 3'd7) begin
            v.state = uart_pkg::tx_stop;
            v.tx    = 1'b1;  // stop bit.
          end else begin
            v.tx = r.shift[1];
          end
        end
      end
      uart_pkg::tx_stop: begin
        if (r.cycle_count == full) begin
          v.state = uart_pkg::tx_idle;
          v.ready = 1'b1;  // write done at end of stop bit.
        end
      end
      default: v.state = uart_pkg::tx_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      r <= init_register;
    end else begin
      r <= v;
    end
  end

  assign bus_out.mem_ready = r.ready;
  assign bus_out.mem_error = 1'b0;
  assign bus_out.mem_rdata = 32'h0;
  assign tx                = r.tx;

  idle_line_high : assert property (
    @(posedge clock) disable iff (reset == 1'b0)
    (r.state == uart_pkg::tx_idle) |-> tx
  );

endmodule

// ==== source/uart_bus_decode.sv ====
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_bus_decode (
  input  logic                clock,
  input  logic                reset,
  input  bus_pkg::mem_in_type  bus_in,
  output bus_pkg::mem_out_type bus_out,
  output bus_pkg::mem_in_type  rx_bus_in,
  input  bus_pkg::mem_out_type rx_bus_out,
  output bus_pkg::mem_in_type  tx_bus_in,
  input  bus_pkg::mem_out_type tx_bus_out
);

  uart_pkg::target_type target;

  logic is_write;
  logic error_ready;

  assign is_write = (bus_in.mem_wstrb != 4'b0000);

  always_comb begin
    if (bus_in.mem_addr == `UART_RX_OFFSET && !is_write) begin
      target = uart_pkg::target_rx;
    end else if (bus_in.mem_addr == `UART_TX_OFFSET && is_write) begin
      target = uart_pkg::target_tx;
    end else begin
      target = uart_pkg::target_none;  // unmapped or wrong direction.
    end
  end

  always_comb begin
    rx_bus_in           = bus_in;
    rx_bus_in.mem_valid = bus_in.mem_valid && (target == uart_pkg::target_rx);
    tx_bus_in           = bus_in;
    tx_bus_in.mem_valid = bus_in.mem_valid && (target == uart_pkg::target_tx);
  end

  // one error pulse per request, the held cycle after it is ignored.
  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      error_ready <= 1'b0;
    end else begin
      error_ready <= bus_in.mem_valid && (target == uart_pkg::target_none) && !error_ready;
    end
  end

  assign bus_out.mem_ready = rx_bus_out.mem_ready | tx_bus_out.mem_ready | error_ready;
  assign bus_out.mem_error = rx_bus_out.mem_error | tx_bus_out.mem_error | error_ready;
  assign bus_out.mem_rdata = rx_bus_out.mem_rdata | tx_bus_out.mem_rdata;

  one_target : assert property (
    @(posedge clock) disable iff (reset == 1'b0)
    !(rx_bus_in.mem_valid && tx_bus_in.mem_valid)
  );

  // a held request must keep its target until acknowledged.
  stable_target : assert property (
    @(posedge clock) disable iff (reset == 1'b0)
    (bus_in.mem_valid && !bus_out.mem_ready) |=> !bus_in.mem_valid || target == $past(target)
  );

endmodule

// ==== source/uart_periph.sv ====
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_periph (
  input  logic                clock,
  input  logic                reset,
  input  bus_pkg::mem_in_type  bus_in,
  output bus_pkg::mem_out_type bus_out,
  input  logic                rx,
  output logic                tx,
  output logic                irpt
);

  bus_pkg::mem_in_type  rx_bus_in;
  bus_pkg::mem_out_type rx_bus_out;
  bus_pkg::mem_in_type  tx_bus_in;
  bus_pkg::mem_out_type tx_bus_out;

  ////////////////////////////////////////////////////////////
  // register decode
  ////////////////////////////////////////////////////////////
  uart_bus_decode bus_decode (
    .clock      (clock),
    .reset      (reset),
    .bus_in     (bus_in),
    .bus_out    (bus_out),
    .rx_bus_in  (rx_bus_in),
    .rx_bus_out (rx_bus_out),
    .tx_bus_in  (tx_bus_in),
    .tx_bus_out (tx_bus_out)
  );

  ////////////////////////////////////////////////////////////
  // serial ports
  ////////////////////////////////////////////////////////////
  uart_rx #(.clocks_per_bit(`UART_CLOCKS_PER_BIT)) receiver (
    .clock   (clock),
    .reset   (reset),
    .bus_in  (rx_bus_in),
    .bus_out (rx_bus_out),
    .irpt    (irpt),
    .rx      (rx)
  );

  uart_tx #(.clocks_per_bit(`UART_CLOCKS_PER_BIT)) transmitter (
    .clock   (clock),
    .reset   (reset),
    .bus_in  (tx_bus_in),
    .bus_out (tx_bus_out),
    .tx      (tx)
  );

endmodule

// ==== verification/uart_periph_tb.sv ====
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_periph_tb;

  localparam int bit_cycles   = `UART_CLOCKS_PER_BIT;
  localparam int bus_timeout  = 16 * bit_cycles;  // a frame plus the longest lead-in.
  localparam int line_timeout = 4 * bit_cycles;

  logic                 clock;
  logic                 reset;
  bus_pkg::mem_in_type  bus_in;
  bus_pkg::mem_out_type bus_out;
  logic                 rx;
  logic                 tx;
  logic                 irpt;

  logic [31:0] rand_state;
  int          check_count;
  int          error_count;
  logic [7:0]  tx_expected[$];  // bytes still to appear on tx.
  logic [7:0]  rx_pending;
  logic        rx_pending_valid;

  uart_periph DUT (
    .clock   (clock),
    .reset   (reset),
    .bus_in  (bus_in),
    .bus_out (bus_out),
    .rx      (rx),
    .tx      (tx),
    .irpt    (irpt)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] value);
    logic [31:0] x;
    x = value ^ (value << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_random(output logic [31:0] value);
    rand_state = xorshift32(rand_state);
    value      = rand_state;
  endtask

  task automatic step_cycle();
    @(posedge clock);
    #1;  // registered outputs have settled here.
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("%0t ns %s", $time, what);
  endtask

  ////////////////////////////////////////////////////////////
  // bus driver and line models
  ////////////////////////////////////////////////////////////
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output logic error, output int latency);
    logic done;
    done    = 1'b0;
    latency = 0;
    bus_in  = '{mem_valid: 1'b1, mem_addr: addr, mem_wdata: wdata, mem_wstrb: wstrb};
    while (!done && latency < bus_timeout) begin
      step_cycle();
      latency++;
      done = bus_out.mem_ready;
    end
    rdata = bus_out.mem_rdata;
    error = bus_out.mem_error;
    if (done) begin
      step_cycle();  // request stays up through the acknowledge cycle.
      compare_value("mem_ready", 32'd0, 32'(bus_out.mem_ready));
    end else begin
      report_failure("bus access timed out without mem_ready");
    end
    bus_in = '0;  // valid drops in the cycle after mem_ready.
  endtask

  task automatic send_frame(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};  // start bit goes out first.
    for (int i = 0; i < 10; i++) begin
      rx = frame[i];
      repeat (bit_cycles) step_cycle();
    end
  endtask

  task automatic receive_tx_frame();
    logic [7:0] data;
    int         cycles;
    cycles = 0;
    data   = 8'h00;
    while (tx !== 1'b0 && cycles < line_timeout) begin
      step_cycle();
      cycles++;
    end
    if (tx !== 1'b0) begin
      report_failure("no start bit seen on tx");
    end else begin
      repeat (bit_cycles / 2) step_cycle();  // centre of the start bit.
      compare_value("tx start bit", 32'd0, 32'(tx));
      for (int i = 0; i < 8; i++) begin
        repeat (bit_cycles) step_cycle();
        data[i] = tx;
      end
      repeat (bit_cycles) step_cycle();
      compare_value("tx stop bit", 32'd1, 32'(tx));
      compare_value("tx byte", 32'(tx_expected.pop_front()), 32'(data));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // operations
  ////////////////////////////////////////////////////////////
  task automatic rx_frame_op();
    logic [31:0] value;
    int          cycles;
    next_random(value);
    send_frame(value[7:0]);
    rx_pending       = value[7:0];
    rx_pending_valid = 1'b1;
    cycles           = 0;
    while (irpt !== 1'b1 && cycles < line_timeout) begin
      step_cycle();
      cycles++;
    end
    compare_value("irpt", 32'd1, 32'(irpt));
  endtask

  task automatic rx_read_pending_op();
    logic [31:0] rdata;
    logic        error;
    int          latency;
    bus_access(`UART_RX_OFFSET, 32'h0, 4'b0000, rdata, error, latency);
    compare_value("mem_rdata", {24'h0, rx_pending}, rdata);
    compare_value("mem_error", 32'd0, 32'(error));
    compare_value("rx read latency", 32'd2, 32'(latency));
    compare_value("irpt", 32'd0, 32'(irpt));
    rx_pending_valid = 1'b0;
  endtask

  task automatic rx_read_wait_op();
    logic [31:0] value;
    logic [31:0] rdata;
    logic        error;
    int          latency;
    next_random(value);
    fork
      bus_access(`UART_RX_OFFSET, 32'h0, 4'b0000, rdata, error, latency);
      begin
        repeat (1 + int'(value[9:8])) step_cycle();
        send_frame(value[7:0]);
      end
    join
    compare_value("mem_rdata", {24'h0, value[7:0]}, rdata);
    compare_value("mem_error", 32'd0, 32'(error));
    compare_value("irpt", 32'd0, 32'(irpt));
  endtask

  task automatic tx_write_op();
    logic [31:0] value;
    logic [31:0] rdata;
    logic        error;
    int          latency;
    next_random(value);
    tx_expected.push_back(value[7:0]);
    fork
      bus_access(`UART_TX_OFFSET, value, 4'b1111, rdata, error, latency);
      receive_tx_frame();
    join
    compare_value("mem_error", 32'd0, 32'(error));
    compare_value("tx write latency", 32'(10 * bit_cycles + 1), 32'(latency));
    compare_value("tx", 32'd1, 32'(tx));  // no second frame from the held request.
  endtask

  task automatic bad_access_op(input int kind);
    logic [31:0] value;
    logic [31:0] addr;
    logic [3:0]  wstrb;
    logic [31:0] rdata;
    logic        error;
    int          latency;
    next_random(value);
    case (kind)
      0: begin
        addr  = value | 32'h8;  // above both registers.
        wstrb = value[7:4];
      end
      1: begin
        addr  = `UART_RX_OFFSET;
        wstrb = value[7:4] | 4'b0001;
      end
      default: begin
        addr  = `UART_TX_OFFSET;
        wstrb = 4'b0000;
      end
    endcase
    bus_access(addr, value, wstrb, rdata, error, latency);
    compare_value("mem_error", 32'd1, 32'(error));
    compare_value("error latency", 32'd1, 32'(latency));
    compare_value("irpt", 32'(rx_pending_valid), 32'(irpt));
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] value;
    reset            = 1'b0;
    bus_in           = '0;
    rx               = 1'b1;
    rand_state       = 32'd63;
    check_count      = 0;
    error_count      = 0;
    rx_pending       = 8'h00;
    rx_pending_valid = 1'b0;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b1;
    step_cycle();

    compare_value("mem_ready", 32'd0, 32'(bus_out.mem_ready));
    compare_value("mem_error", 32'd0, 32'(bus_out.mem_error));
    compare_value("irpt", 32'd0, 32'(irpt));
    compare_value("tx", 32'd1, 32'(tx));

    rx_frame_op();
    rx_read_pending_op();
    rx_read_wait_op();
    tx_write_op();
    for (int kind = 0; kind < 3; kind++) begin
      bad_access_op(kind);
    end

    // random mix, the model decides which rx operation fits.
    for (int n = 0; n < 40; n++) begin
      next_random(value);
      case (value[1:0])
        2'd0: begin
          if (rx_pending_valid) begin
            rx_read_pending_op();
          end else begin
            rx_frame_op();
          end
        end
        2'd1: begin
          if (rx_pending_valid) begin
            rx_read_pending_op();
          end else begin
            rx_read_wait_op();
          end
        end
        2'd2: tx_write_op();
        default: bad_access_op(int'(value[7:6]) % 3);
      endcase
      repeat (int'(value[5:2])) step_cycle();  // idle gap.
    end

    if (tx_expected.size() != 0) begin
      report_failure("bytes written for tx never appeared on the line");
    end
    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== uart_periph.f ====
+incdir+source
source/bus_pkg.sv
source/uart_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_bus_decode.sv
source/uart_periph.sv
verification/uart_periph_tb.sv

// ==== build.sh ====
#!/bin/sh
# compile the testbench with Verilator, run it, and judge the run from its log
rm -rf obj_dir compile.log sim.log
verilator --binary --timing --assert -f uart_periph.f --top-module uart_periph_tb \
  -o uart_periph_sim > compile.log 2>&1 || { cat compile.log; exit 1; }
./obj_dir/uart_periph_sim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
